// File: hw/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module arch_regfile
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     we,
	input  rob_pkg::lc3b_reg         waddr,
	input  logic [`ROB_DATA_W-1:0]   wdata,
	input  rob_pkg::lc3b_reg         raddr1,
	input  rob_pkg::lc3b_reg         raddr2,
	output logic [`ROB_DATA_W-1:0]   rdata1,
	output logic [`ROB_DATA_W-1:0]   rdata2
);

	logic [`ROB_DATA_W-1:0] regs [`ROB_NUM_REGS];   // Committed state.

	// Written only at retirement.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `ROB_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we)
			regs[waddr] <= wdata;
	end

	// Reads are combinational, no write bypass.
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: hw/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_commit
(
	input  logic                     empty,
	input  logic                     head_valid,
	input  rob_pkg::lc3b_opcode      head_opcode,
	input  rob_pkg::lc3b_reg         head_dest,
	input  logic [`ROB_DATA_W-1:0]   head_value,
	input  logic                     head_predict,
	input  rob_pkg::lc3b_word        head_pc,
	input  rob_pkg::lc3b_bht_out     head_bht,
	output logic                     re,             // Head retires this cycle.
	output logic                     flush,
	output logic                     rf_we,
	output rob_pkg::lc3b_reg         rf_waddr,
	output logic [`ROB_DATA_W-1:0]   rf_wdata,
	output logic                     mispredict,
	output rob_pkg::lc3b_word        redirect_pc,
	output logic                     redirect_taken,
	output logic                     bht_upd_valid,
	output logic                     bht_upd_index_unused_guard,
	output rob_pkg::lc3b_bht_out     bht_upd_index,
	output logic                     bht_upd_taken
);

	import rob_pkg::*;

	logic head_is_br;     // Head is a conditional branch.
	logic taken;          // Resolved outcome, bit 0 of the value.
	logic wrong;          // Prediction disagrees with outcome.

	// ==================================================
	// Retirement decision.
	// ==================================================
	assign re         = ~empty & head_valid;     // Same-cycle retire.
	assign head_is_br = (head_opcode == op_br);
	assign taken      = head_value[0];
	assign wrong      = re & head_is_br & (head_predict != taken);

	// Architectural write for register producers.
	assign rf_we    = re & writes_reg(head_opcode);
	assign rf_waddr = head_dest;
	assign rf_wdata = head_value;

	// ==================================================
	// Branch resolution.
	// ==================================================
	assign flush          = wrong;          // Drops every younger entry.
	assign mispredict     = wrong;
	assign redirect_pc    = head_pc;        // Fetch recomputes the target.
	assign redirect_taken = taken;

	// Every retiring branch trains the history table.
	assign bht_upd_valid = re & head_is_br;
	assign bht_upd_index = head_bht;
	assign bht_upd_taken = taken;

	assign bht_upd_index_unused_guard = 1'b0;

endmodule

`default_nettype wire

// File: hw/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// ==================================================
// Reorder buffer sizing.
// ==================================================

`define ROB_TAG_W     3   // Eight entries.
`define ROB_DATA_W    16  // Result word.
`define ROB_NUM_REGS  8   // Architectural registers.
`define ROB_PC_W      16  // Fetch address width.

`endif

// File: hw/rob_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_dispatch
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     flush,
	input  logic                     disp_valid,
	input  rob_pkg::lc3b_opcode      disp_opcode,
	input  rob_pkg::lc3b_reg         disp_dest,
	input  rob_pkg::lc3b_reg         disp_sr1,
	input  rob_pkg::lc3b_reg         disp_sr2,
	input  logic                     full,
	input  logic [`ROB_TAG_W-1:0]    tail_tag,       // Tag given to this dispatch.
	input  logic                     commit_valid,   // Register-writing retirement.
	input  rob_pkg::lc3b_reg         commit_dest,
	input  logic [`ROB_TAG_W-1:0]    commit_tag,
	input  logic [`ROB_DATA_W-1:0]   rf_sr1_value,
	input  logic [`ROB_DATA_W-1:0]   rf_sr2_value,
	input  logic [`ROB_DATA_W-1:0]   rob_sr1_value,
	input  logic                     rob_sr1_valid,
	input  logic [`ROB_DATA_W-1:0]   rob_sr2_value,
	input  logic                     rob_sr2_valid,
	output logic                     accept,         // Store write enable.
	output logic [`ROB_TAG_W-1:0]    rob_sr1_tag,
	output logic [`ROB_TAG_W-1:0]    rob_sr2_tag,
	output logic                     sr1_ready,
	output logic [`ROB_DATA_W-1:0]   sr1_value,
	output logic                     sr2_ready,
	output logic [`ROB_DATA_W-1:0]   sr2_value
);

	import rob_pkg::*;

	// Register alias table.
	logic [`ROB_NUM_REGS-1:0] pending;                   // Writer in flight.
	logic [`ROB_TAG_W-1:0]    rat_tag [`ROB_NUM_REGS];   // Youngest writer's tag.

	logic                     rename;                    // Dispatch claims disp_dest.
	logic                     commit_clear;

	// Full and flush both hold the instruction at the source.
	assign accept = disp_valid & ~full & ~flush;
	assign rename = accept & writes_reg(disp_opcode);

	// Only the youngest writer may release the mark.
	assign commit_clear = commit_valid & pending[commit_dest]
		& (rat_tag[commit_dest] == commit_tag)
		& ~(rename & (disp_dest == commit_dest));

	// ==================================================
	// Alias table update.
	// ==================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pending <= '0;
			for (int i = 0; i < `ROB_NUM_REGS; i++)
				rat_tag[i] <= '0;
		end
		else if (flush)
			pending <= '0;                       // All speculative writers gone.
		else
		begin
			if (commit_clear)
				pending[commit_dest] <= 1'b0;    // Value now lives in the register file.
			if (rename)
			begin
				pending[disp_dest] <= 1'b1;
				rat_tag[disp_dest] <= tail_tag;
			end
		end
	end

	// ==================================================
	// Operand selection.
	// ==================================================
	assign rob_sr1_tag = rat_tag[disp_sr1];
	assign rob_sr2_tag = rat_tag[disp_sr2];

	// Pending source takes value and ready from its writer's entry.
	assign sr1_ready = pending[disp_sr1] ? rob_sr1_valid : 1'b1;
	assign sr1_value = pending[disp_sr1] ? rob_sr1_value : rf_sr1_value;
	assign sr2_ready = pending[disp_sr2] ? rob_sr2_valid : 1'b1;
	assign sr2_value = pending[disp_sr2] ? rob_sr2_value : rf_sr2_value;

endmodule

`default_nettype wire

// File: hw/rob_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_entry_store #(
	parameter int tag_width  = `ROB_TAG_W,
	parameter int data_width = `ROB_DATA_W
)
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     flush,          // Empties the buffer.
	input  logic                     we,             // Tail write, already gated.
	input  logic                     re,             // Head retire.
	input  rob_pkg::lc3b_opcode      inst_in,
	input  rob_pkg::lc3b_reg         dest_in,
	input  logic [data_width-1:0]    value_in,
	input  logic                     predict_in,
	input  rob_pkg::lc3b_word        orig_pc_in,
	input  rob_pkg::lc3b_bht_out     bht_in,
	input  logic                     cmpl_we,        // Completion by tag.
	input  logic [tag_width-1:0]     cmpl_addr,
	input  logic [data_width-1:0]    cmpl_value,
	input  logic [tag_width-1:0]     sr1_read_addr,
	input  logic [tag_width-1:0]     sr2_read_addr,
	output rob_pkg::lc3b_opcode      inst_out,
	output rob_pkg::lc3b_reg         dest_out,
	output logic                     valid_out,
	output logic [data_width-1:0]    value_out,
	output logic                     predict_out,
	output rob_pkg::lc3b_word        orig_pc_out,
	output rob_pkg::lc3b_bht_out     bht_out,
	output logic [tag_width-1:0]     w_addr_out,     // Tail tag.
	output logic [tag_width-1:0]     r_addr_out,     // Head tag.
	output logic                     empty,
	output logic                     full,
	output logic [data_width-1:0]    sr1_value_out,
	output logic                     sr1_valid_out,
	output logic [data_width-1:0]    sr2_value_out,
	output logic                     sr2_valid_out
);

	import rob_pkg::*;

	localparam int depth = 2**tag_width;

	logic [tag_width-1:0]  r_addr;          // Head pointer.
	logic [tag_width-1:0]  w_addr;          // Tail pointer.
	logic [tag_width:0]    cnt;             // Occupancy, one bit wider.

	// Per-entry fields.
	logic                  valid   [depth];
	logic [data_width-1:0] value   [depth];
	lc3b_reg               dest    [depth];
	lc3b_opcode            inst    [depth];
	logic                  predict [depth];
	lc3b_word              orig_pc [depth];
	lc3b_bht_out           bht     [depth];

	assign empty = (cnt == '0);
	assign full  = (cnt == depth[tag_width:0]);

	// ==================================================
	// Head view and tag-addressed read ports.
	// ==================================================
	assign inst_out    = inst[r_addr];
	assign dest_out    = dest[r_addr];
	assign valid_out   = valid[r_addr];
	assign value_out   = value[r_addr];
	assign predict_out = predict[r_addr];
	assign orig_pc_out = orig_pc[r_addr];
	assign bht_out     = bht[r_addr];

	assign w_addr_out = w_addr;
	assign r_addr_out = r_addr;

	assign sr1_value_out = value[sr1_read_addr]; // Operand forwarding.
	assign sr1_valid_out = valid[sr1_read_addr];
	assign sr2_value_out = value[sr2_read_addr];
	assign sr2_valid_out = valid[sr2_read_addr];

	// ==================================================
	// Pointers, count and valid bits.
	// ==================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			r_addr <= '0;
			w_addr <= '0;
			cnt    <= '0;
			for (int i = 0; i < depth; i++)
				valid[i] <= 1'b0;
		end
		else if (flush)
		begin
			// Mispredict wipes every entry, next tag is zero.
			r_addr <= '0;
			w_addr <= '0;
			cnt    <= '0;
			for (int i = 0; i < depth; i++)
				valid[i] <= 1'b0;
		end
		else
		begin
			if (we)
			begin
				case (inst_in)
					op_br, op_lea, op_jsr, op_str, op_stb: valid[w_addr] <= 1'b1; // Nothing to wait on.
					default: valid[w_addr] <= 1'b0;
				endcase
				w_addr <= w_addr + 1'b1;
			end
			if (cmpl_we)
				valid[cmpl_addr] <= 1'b1;     // Result has arrived.
			if (re)
			begin
				valid[r_addr] <= 1'b0;        // Free the head slot.
				r_addr        <= r_addr + 1'b1;
			end
			if (we && !re)
				cnt <= cnt + 1'b1;
			else if (re && !we)
				cnt <= cnt - 1'b1;
		end
	end

	// ==================================================
	// Payload fields.
	// ==================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < depth; i++)
			begin
				value[i]   <= '0;
				dest[i]    <= '0;
				inst[i]    <= op_br;
				predict[i] <= 1'b0;
				orig_pc[i] <= '0;
				bht[i]     <= '0;
			end
		end
		else if (!flush)
		begin
			if (we)
			begin
				value[w_addr]   <= value_in;   // Branch outcome or precomputed result.
				dest[w_addr]    <= dest_in;
				inst[w_addr]    <= inst_in;
				predict[w_addr] <= predict_in;
				orig_pc[w_addr] <= orig_pc_in;
				bht[w_addr]     <= bht_in;
			end
			if (cmpl_we)
				value[cmpl_addr] <= cmpl_value;
		end
	end

endmodule

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

	// ==================================================
	// LC-3b style opcode set, four bit encoding.
	// ==================================================
	typedef enum logic [3:0] {
		op_br  = 4'h0,
		op_add = 4'h1,
		op_ld  = 4'h2,
		op_st  = 4'h3,
		op_jsr = 4'h4,
		op_and = 4'h5,
		op_ldr = 4'h6,
		op_str = 4'h7,
		op_not = 4'h8,
		op_ldi = 4'h9,
		op_sti = 4'ha,
		op_jmp = 4'hb,
		op_lea = 4'hc,
		op_ldb = 4'hd,
		op_stb = 4'he,
		op_shf = 4'hf
	} lc3b_opcode;

	typedef logic [2:0]           lc3b_reg;     // Register number.
	typedef logic [`ROB_PC_W-1:0] lc3b_word;    // PC value.
	typedef logic [3:0]           lc3b_bht_out; // History index.

	// Branches, stores and jumps leave the register file alone.
	function automatic logic writes_reg(input lc3b_opcode op);
		case (op)
			op_br, op_st, op_str, op_stb, op_sti, op_jmp: writes_reg = 1'b0;
			default: writes_reg = 1'b1;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_top
(
	input  logic                     clk,
	input  logic                     arst_n,
	// Dispatch.
	input  logic                     disp_valid,
	input  rob_pkg::lc3b_opcode      disp_opcode,
	input  rob_pkg::lc3b_reg         disp_dest,
	input  rob_pkg::lc3b_reg         disp_sr1,
	input  rob_pkg::lc3b_reg         disp_sr2,
	input  logic [`ROB_DATA_W-1:0]   disp_value,
	input  logic                     disp_predict,
	input  rob_pkg::lc3b_word        disp_pc,
	input  rob_pkg::lc3b_bht_out     disp_bht,
	output logic                     disp_stall,
	output logic [`ROB_TAG_W-1:0]    disp_tag,
	// Operands.
	output logic                     sr1_ready,
	output logic [`ROB_DATA_W-1:0]   sr1_value,
	output logic [`ROB_TAG_W-1:0]    sr1_tag,
	output logic                     sr2_ready,
	output logic [`ROB_DATA_W-1:0]   sr2_value,
	output logic [`ROB_TAG_W-1:0]    sr2_tag,
	// Completion.
	input  logic                     cmpl_valid,
	input  logic [`ROB_TAG_W-1:0]    cmpl_tag,
	input  logic [`ROB_DATA_W-1:0]   cmpl_value,
	// Retirement.
	output logic                     commit_valid,
	output rob_pkg::lc3b_reg         commit_dest,
	output logic [`ROB_DATA_W-1:0]   commit_value,
	output rob_pkg::lc3b_opcode      commit_opcode,
	// Redirect and history update.
	output logic                     mispredict,
	output rob_pkg::lc3b_word        redirect_pc,
	output logic                     redirect_taken,
	output logic                     bht_upd_valid,
	output rob_pkg::lc3b_bht_out     bht_upd_index,
	output logic                     bht_upd_taken
);

	import rob_pkg::*;

	// ==================================================
	// Internal nets.
	// ==================================================
	logic                   accept;         // Tail write.
	logic                   flush;
	logic                   empty;
	logic                   head_valid;
	logic                   head_predict;
	lc3b_word               head_pc;
	lc3b_bht_out            head_bht;
	logic [`ROB_TAG_W-1:0]  head_tag;
	logic                   rf_we;
	lc3b_reg                rf_waddr;
	logic [`ROB_DATA_W-1:0] rf_wdata;
	logic [`ROB_DATA_W-1:0] rf_sr1_value, rf_sr2_value;
	logic [`ROB_DATA_W-1:0] rob_sr1_value, rob_sr2_value;
	logic                   rob_sr1_valid, rob_sr2_valid;

	rob_entry_store u_store (
		.clk(clk), .arst_n(arst_n), .flush(flush),
		.we(accept), .re(commit_valid),
		.inst_in(disp_opcode), .dest_in(disp_dest), .value_in(disp_value),
		.predict_in(disp_predict), .orig_pc_in(disp_pc), .bht_in(disp_bht),
		.cmpl_we(cmpl_valid), .cmpl_addr(cmpl_tag), .cmpl_value(cmpl_value),
		.sr1_read_addr(sr1_tag), .sr2_read_addr(sr2_tag),
		.inst_out(commit_opcode), .dest_out(commit_dest), .valid_out(head_valid),
		.value_out(commit_value), .predict_out(head_predict),
		.orig_pc_out(head_pc), .bht_out(head_bht),
		.w_addr_out(disp_tag), .r_addr_out(head_tag),
		.empty(empty), .full(disp_stall),
		.sr1_value_out(rob_sr1_value), .sr1_valid_out(rob_sr1_valid),
		.sr2_value_out(rob_sr2_value), .sr2_valid_out(rob_sr2_valid)
	);

	rob_dispatch u_dispatch (
		.clk(clk), .arst_n(arst_n), .flush(flush),
		.disp_valid(disp_valid), .disp_opcode(disp_opcode), .disp_dest(disp_dest),
		.disp_sr1(disp_sr1), .disp_sr2(disp_sr2),
		.full(disp_stall), .tail_tag(disp_tag),
		.commit_valid(rf_we), .commit_dest(rf_waddr), .commit_tag(head_tag),
		.rf_sr1_value(rf_sr1_value), .rf_sr2_value(rf_sr2_value),
		.rob_sr1_value(rob_sr1_value), .rob_sr1_valid(rob_sr1_valid),
		.rob_sr2_value(rob_sr2_value), .rob_sr2_valid(rob_sr2_valid),
		.accept(accept), .rob_sr1_tag(sr1_tag), .rob_sr2_tag(sr2_tag),
		.sr1_ready(sr1_ready), .sr1_value(sr1_value),
		.sr2_ready(sr2_ready), .sr2_value(sr2_value)
	);

	rob_commit u_commit (
		.empty(empty), .head_valid(head_valid), .head_opcode(commit_opcode),
		.head_dest(commit_dest), .head_value(commit_value),
		.head_predict(head_predict), .head_pc(head_pc), .head_bht(head_bht),
		.re(commit_valid), .flush(flush),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.mispredict(mispredict), .redirect_pc(redirect_pc),
		.redirect_taken(redirect_taken),
		.bht_upd_valid(bht_upd_valid), .bht_upd_index_unused_guard(),
		.bht_upd_index(bht_upd_index), .bht_upd_taken(bht_upd_taken)
	);

	arch_regfile u_regfile (
		.clk(clk), .arst_n(arst_n),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.raddr1(disp_sr1), .raddr2(disp_sr2),
		.rdata1(rf_sr1_value), .rdata2(rf_sr2_value)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -f tb.f --top-module tb_rob_top -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/Vtb_rob_top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$log"; then
	exit 0
fi
exit 1

// File: tb.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_entry_store.sv
hw/rob_dispatch.sv
hw/rob_commit.sv
hw/arch_regfile.sv
hw/rob_top.sv
tests/tb_rob_top.sv

// File: tests/tb_rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module tb_rob_top;

	import rob_pkg::*;

	localparam int num_tests   = 5;
	localparam int test_cycles = 800;     // Worst length of one test.
	localparam int clk_period  = 8;

	// DUT inputs.
	logic                   clk;
	logic                   arst_n;
	logic                   disp_valid;
	lc3b_opcode             disp_opcode;
	lc3b_reg                disp_dest, disp_sr1, disp_sr2;
	logic [`ROB_DATA_W-1:0] disp_value;
	logic                   disp_predict;
	lc3b_word               disp_pc;
	lc3b_bht_out            disp_bht;
	logic                   cmpl_valid;
	logic [`ROB_TAG_W-1:0]  cmpl_tag;
	logic [`ROB_DATA_W-1:0] cmpl_value;

	// DUT outputs.
	logic                   disp_stall;
	logic [`ROB_TAG_W-1:0]  disp_tag;
	logic                   sr1_ready, sr2_ready;
	logic [`ROB_DATA_W-1:0] sr1_value, sr2_value;
	logic [`ROB_TAG_W-1:0]  sr1_tag, sr2_tag;
	logic                   commit_valid;
	lc3b_reg                commit_dest;
	logic [`ROB_DATA_W-1:0] commit_value;
	lc3b_opcode             commit_opcode;
	logic                   mispredict;
	lc3b_word               redirect_pc;
	logic                   redirect_taken;
	logic                   bht_upd_valid;
	lc3b_bht_out            bht_upd_index;
	logic                   bht_upd_taken;

	int                     errors;
	int                     test_errors;   // Error count when the last test closed.
	int                     tests_run;
	logic [`ROB_TAG_W-1:0]  next_tag;      // Expected tail tag.
	logic [`ROB_DATA_W-1:0] model_rf [`ROB_NUM_REGS];   // Committed register values.

	rob_top u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Watchdog sized from test count and worst test length.
	initial
	begin
		#(num_tests * test_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, run did not finish", num_tests * test_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==================================================
	// Helpers.
	// ==================================================
	function automatic logic updates_register(input lc3b_opcode op);
		updates_register = !(op inside {op_br, op_st, op_str, op_stb, op_sti, op_jmp});
	endfunction

	task automatic expect_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val)
		begin
			$display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_val, act_val);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;                              // Drive just after the edge.
	endtask

	// One accepted dispatch, tag checked against the expected tail.
	task automatic dispatch(input lc3b_opcode op, input lc3b_reg dest,
		input logic [`ROB_DATA_W-1:0] value, input logic predict,
		input lc3b_word pc, input lc3b_bht_out bht);
		disp_valid   = 1'b1;
		disp_opcode  = op;
		disp_dest    = dest;
		disp_value   = value;
		disp_predict = predict;
		disp_pc      = pc;
		disp_bht     = bht;
		@(negedge clk);
		expect_value("disp_stall", 32'd0, 32'(disp_stall));
		expect_value("disp_tag", 32'(next_tag), 32'(disp_tag));
		next_cycle();
		disp_valid = 1'b0;
		next_tag   = next_tag + 1'b1;
	endtask

	task automatic complete(input logic [`ROB_TAG_W-1:0] tag,
		input logic [`ROB_DATA_W-1:0] value);
		cmpl_valid = 1'b1;
		cmpl_tag   = tag;
		cmpl_value = value;
		next_cycle();
		cmpl_valid = 1'b0;
	endtask

	// Waits for the next retirement and checks it, then steps past it.
	task automatic retire_check(input lc3b_opcode op, input lc3b_reg dest,
		input logic [`ROB_DATA_W-1:0] value, input logic predict,
		input lc3b_word pc, input lc3b_bht_out bht);
		int   waited;
		logic is_br;
		waited = 0;
		is_br  = (op == op_br);
		@(negedge clk);
		while (!commit_valid && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (!commit_valid)
		begin
			$display("Expected retirement of dest %0d did not happen within 20 cycles", dest);
			errors++;
		end
		else
		begin
			expect_value("commit_opcode", 32'(op), 32'(commit_opcode));
			expect_value("commit_dest", 32'(dest), 32'(commit_dest));
			expect_value("commit_value", 32'(value), 32'(commit_value));
			expect_value("mispredict", 32'(is_br && (predict != value[0])), 32'(mispredict));
			expect_value("bht_upd_valid", 32'(is_br), 32'(bht_upd_valid));
			if (is_br)
			begin
				expect_value("redirect_pc", 32'(pc), 32'(redirect_pc));
				expect_value("redirect_taken", 32'(value[0]), 32'(redirect_taken));
				expect_value("bht_upd_index", 32'(bht), 32'(bht_upd_index));
				expect_value("bht_upd_taken", 32'(value[0]), 32'(bht_upd_taken));
			end
		end
		if (updates_register(op))
			model_rf[dest] = value;      // Architectural write on this edge.
		next_cycle();
	endtask

	// Both sources unpended, values from the model register file.
	task automatic check_operands(input lc3b_reg r1, input lc3b_reg r2);
		disp_sr1 = r1;
		disp_sr2 = r2;
		@(negedge clk);
		expect_value("sr1_ready", 32'd1, 32'(sr1_ready));
		expect_value("sr1_value", 32'(model_rf[r1]), 32'(sr1_value));
		expect_value("sr2_ready", 32'd1, 32'(sr2_ready));
		expect_value("sr2_value", 32'(model_rf[r2]), 32'(sr2_value));
		next_cycle();
	endtask

	task automatic report(input string name);
		if (errors == test_errors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - test_errors);
		test_errors = errors;
		tests_run++;
	endtask

	// ==================================================
	// Tests.
	// ==================================================
	task automatic test_allocation();
		@(negedge clk);
		expect_value("commit_valid", 32'd0, 32'(commit_valid));
		expect_value("mispredict", 32'd0, 32'(mispredict));
		expect_value("bht_upd_valid", 32'd0, 32'(bht_upd_valid));
		expect_value("disp_stall", 32'd0, 32'(disp_stall));
		next_cycle();
		for (int i = 0; i < 8; i++)
			dispatch(op_add, lc3b_reg'(i), 16'h0, 1'b0, 16'h0, 4'h0);
		@(negedge clk);
		expect_value("disp_stall", 32'd1, 32'(disp_stall));
		expect_value("commit_valid", 32'd0, 32'(commit_valid));
		next_cycle();
		disp_valid  = 1'b1;              // Ninth dispatch into a full buffer.
		disp_opcode = op_add;
		disp_dest   = 3'd1;
		next_cycle();
		disp_valid = 1'b0;
		@(negedge clk);
		expect_value("disp_stall", 32'd1, 32'(disp_stall));   // Count still eight.
		expect_value("disp_tag", 32'(next_tag), 32'(disp_tag));
		expect_value("commit_valid", 32'd0, 32'(commit_valid));
		next_cycle();
		report("allocation and full");
	endtask

	task automatic test_completion();
		logic [`ROB_DATA_W-1:0] vals [8];
		for (int i = 0; i < 8; i++)
			vals[i] = 16'($urandom);
		for (int t = 7; t > 0; t--)
		begin
			complete(3'(t), vals[t]);
			@(negedge clk);
			expect_value("commit_valid", 32'd0, 32'(commit_valid));   // Head still waits.
			next_cycle();
		end
		complete(3'd0, vals[0]);
		for (int i = 0; i < 8; i++)
			retire_check(op_add, lc3b_reg'(i), vals[i], 1'b0, 16'h0, 4'h0);
		@(negedge clk);
		expect_value("commit_valid", 32'd0, 32'(commit_valid));
		next_cycle();
		for (int r = 0; r < 8; r++)
			check_operands(lc3b_reg'(r), lc3b_reg'(7 - r));
		report("out of order completion");
	endtask

	task automatic test_renaming();
		logic [`ROB_TAG_W-1:0]  tag;
		logic [`ROB_DATA_W-1:0] v;
		tag = next_tag;
		v   = 16'($urandom);
		dispatch(op_add, 3'd3, 16'h0, 1'b0, 16'h0, 4'h0);
		disp_sr1 = 3'd3;
		disp_sr2 = 3'd4;
		@(negedge clk);
		expect_value("sr1_ready", 32'd0, 32'(sr1_ready));     // Waiting on the writer.
		expect_value("sr1_tag", 32'(tag), 32'(sr1_tag));
		expect_value("sr2_ready", 32'd1, 32'(sr2_ready));
		expect_value("sr2_value", 32'(model_rf[4]), 32'(sr2_value));
		next_cycle();
		disp_sr1 = 3'd4;                 // Same writer seen on the second port.
		disp_sr2 = 3'd3;
		@(negedge clk);
		expect_value("sr2_ready", 32'd0, 32'(sr2_ready));
		expect_value("sr2_tag", 32'(tag), 32'(sr2_tag));
		expect_value("sr1_ready", 32'd1, 32'(sr1_ready));
		expect_value("sr1_value", 32'(model_rf[4]), 32'(sr1_value));
		next_cycle();
		disp_sr1 = 3'd3;
		complete(tag, v);
		@(negedge clk);
		expect_value("sr1_ready", 32'd1, 32'(sr1_ready));     // Forwarded from the entry.
		expect_value("sr1_value", 32'(v), 32'(sr1_value));
		expect_value("sr2_ready", 32'd1, 32'(sr2_ready));
		expect_value("sr2_value", 32'(v), 32'(sr2_value));
		expect_value("commit_valid", 32'd1, 32'(commit_valid));
		expect_value("commit_dest", 32'd3, 32'(commit_dest));
		expect_value("commit_value", 32'(v), 32'(commit_value));
		model_rf[3] = v;
		next_cycle();
		@(negedge clk);
		expect_value("sr1_ready", 32'd1, 32'(sr1_ready));     // Now from the register file.
		expect_value("sr1_value", 32'(v), 32'(sr1_value));
		expect_value("sr2_ready", 32'd1, 32'(sr2_ready));
		expect_value("sr2_value", 32'(v), 32'(sr2_value));
		expect_value("commit_valid", 32'd0, 32'(commit_valid));
		next_cycle();
		report("operand renaming");
	endtask

	task automatic test_mispredict();
		logic [`ROB_TAG_W-1:0]  older;
		logic [`ROB_DATA_W-1:0] v;
		older = next_tag;
		v     = 16'($urandom);
		dispatch(op_add, 3'd5, 16'h0, 1'b0, 16'h0, 4'h0);        // Older writer, waiting.
		dispatch(op_br, 3'd0, 16'h0000, 1'b1, 16'h3040, 4'h9);   // Predicted taken, falls through.
		dispatch(op_lea, 3'd5, 16'h7777, 1'b0, 16'h0, 4'h0);     // Younger and already valid.
		dispatch(op_add, 3'd6, 16'h0, 1'b0, 16'h0, 4'h0);
		complete(older, v);
		retire_check(op_add, 3'd5, v, 1'b0, 16'h0, 4'h0);
		retire_check(op_br, 3'd0, 16'h0000, 1'b1, 16'h3040, 4'h9);
		next_tag = '0;                   // Flush empties the buffer.
		for (int i = 0; i < 3; i++)
		begin
			@(negedge clk);
			expect_value("commit_valid", 32'd0, 32'(commit_valid));
			expect_value("mispredict", 32'd0, 32'(mispredict));
			expect_value("disp_stall", 32'd0, 32'(disp_stall));
			expect_value("disp_tag", 32'd0, 32'(disp_tag));
			next_cycle();
		end
		check_operands(3'd5, 3'd6);
		report("branch misprediction");
	endtask

	task automatic test_correct_branch();
		logic [`ROB_DATA_W-1:0] v;
		v = 16'($urandom);
		dispatch(op_br, 3'd0, 16'h0001, 1'b1, 16'h3100, 4'h2);
		retire_check(op_br, 3'd0, 16'h0001, 1'b1, 16'h3100, 4'h2);
		dispatch(op_str, 3'd2, v, 1'b0, 16'h3102, 4'h0);
		retire_check(op_str, 3'd2, v, 1'b0, 16'h3102, 4'h0);
		dispatch(op_stb, 3'd4, ~v, 1'b0, 16'h3104, 4'h0);
		retire_check(op_stb, 3'd4, ~v, 1'b0, 16'h3104, 4'h0);
		for (int r = 0; r < 4; r++)
			check_operands(lc3b_reg'(r), lc3b_reg'(r + 4));
		report("correct prediction and stores");
	endtask

	// ==================================================
	// Main sequence.
	// ==================================================
	initial
	begin
		void'($urandom(92165));
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		next_tag     = '0;
		arst_n       = 1'b0;
		disp_valid   = 1'b0;
		disp_opcode  = op_br;
		disp_dest    = '0;
		disp_sr1     = '0;
		disp_sr2     = '0;
		disp_value   = '0;
		disp_predict = 1'b0;
		disp_pc      = '0;
		disp_bht     = '0;
		cmpl_valid   = 1'b0;
		cmpl_tag     = '0;
		cmpl_value   = '0;
		for (int i = 0; i < `ROB_NUM_REGS; i++)
			model_rf[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_allocation();
		test_completion();
		test_renaming();
		test_mispredict();
		test_correct_branch();

		$display("Tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
